/* tests/shuffle_tests.txt */
# name src_id dst_id rotate rd_base rd_stride wr_base wr_stride n reconfigure
# ids 2 = VMEM1 and 3 = VMEM2; bases and strides in hex, n and flags in decimal
copy_1to2       2 3 0 0010 0001 0100 0003 8 1
rotate_1to2     2 3 1 0020 0002 0200 0001 9 1
copy_2to1       3 2 0 0040 0004 0300 0002 6 1
rotate_2to1     3 2 1 0050 0001 0050 0001 7 1
copy_inside_1   2 2 0 0000 0001 0800 0001 5 1
rotate_inside_2 3 3 1 1000 0010 2000 0010 10 1
rerun_inside_2  3 3 1 1000 0010 2000 0010 10 0
wrap_around     2 3 0 fffe 0001 fffd 0002 4 1
single_rotate   3 2 1 0007 0003 0009 0005 1 1
three_rotate    2 3 1 0030 0007 0600 0001 3 1
empty_run       2 3 0 0000 0001 0000 0001 0 1
rerun_empty     2 3 0 0000 0001 0000 0001 0 0
after_empty     2 3 1 0100 0001 0400 ffff 5 1

/* compile.f */
common/shuffler_pkg.sv
control/shuffle_decoder.sv
control/shuffle_sequencer.sv
control/stride_walker.sv
datapath/lane_skew.sv
datapath/bank_rotator.sv
datapath/vmem_port_mux.sv
verilog/data_shuffler.sv
tests/shuffle_checker.sv
tests/tb_data_shuffler.sv

/* Makefile */
# Verilator flow for the tensor data shuffler

VERILATOR ?= verilator
TOP       ?= tb_data_shuffler
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST)) tests/shuffle_tests.txt
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_data_shuffler.sv */
/*
 * Testbench for the tensor data shuffler.
 * Two-memory model, test cases from the data file, instruction stimulus.
 */
`timescale 1ns/1ps

module tb_data_shuffler import shuffler_pkg::*; ();

    localparam logic [31:0] SEED         = 32'h3511aca4;
    localparam int          DONE_TIMEOUT = 200;
    localparam int          QUIET_CYCLES = 8;

    logic           clk = 1'b0;
    logic           reset;
    shuffle_instr_t instr;
    lane_data_vec_t vmem1_rdata = '0;
    lane_data_vec_t vmem2_rdata = '0;
    vmem_port_t     vmem1;
    vmem_port_t     vmem2;
    logic           done;

    // settings of the running case, shared with the checker
    logic [127:0] test_name;
    mem_id_t      src_id;
    mem_id_t      dst_id;
    logic         rotate;
    buf_addr_t    rd_base;
    stride_t      rd_stride;
    buf_addr_t    wr_base;
    stride_t      wr_stride;
    iter_t        n_iter;
    logic         test_end;
    int           pass_count;
    int           fail_count;

    logic [31:0] rng;
    logic        aborted;
    lane_data_t  mem1_store [int];
    lane_data_t  mem2_store [int];

    always #2 clk = ~clk;

    data_shuffler data_shuffler_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .vmem1_rdata (vmem1_rdata),
        .vmem2_rdata (vmem2_rdata),
        .vmem1       (vmem1),
        .vmem2       (vmem2),
        .done        (done)
    );

    shuffle_checker checker_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // initial contents, a function of memory, lane and address
    function automatic lane_data_t mem_word(input mem_id_t m, input int lane, input buf_addr_t a);
        return xorshift(xorshift(SEED ^ {5'd0, m, 8'(lane), a}));
    endfunction

    function automatic lane_data_t read_word(input mem_id_t m, input int lane, input buf_addr_t a);
        int key;
        key = lane * 65536 + int'(a);
        if (m == mem_id_t'(VMEM1_ID) && mem1_store.exists(key)) begin
            return mem1_store[key];
        end
        if (m == mem_id_t'(VMEM2_ID) && mem2_store.exists(key)) begin
            return mem2_store[key];
        end
        return mem_word(m, lane, a);
    endfunction

    // ========================================================================
    // memory model, one bank per lane, read data one cycle after request
    // ========================================================================
    always @(posedge clk) begin
        for (int n = 0; n < NUM_LANES; n++) begin
            if (reset) begin
                vmem1_rdata[n*DATA_W +: DATA_W] <= '0;
                vmem2_rdata[n*DATA_W +: DATA_W] <= '0;
            end else begin
                if (vmem1.read_req[n]) begin
                    vmem1_rdata[n*DATA_W +: DATA_W] <= read_word(mem_id_t'(VMEM1_ID), n,
                        vmem1.read_addr[n*ADDR_W +: ADDR_W]);
                end
                if (vmem2.read_req[n]) begin
                    vmem2_rdata[n*DATA_W +: DATA_W] <= read_word(mem_id_t'(VMEM2_ID), n,
                        vmem2.read_addr[n*ADDR_W +: ADDR_W]);
                end
                if (vmem1.write_req[n]) begin
                    mem1_store[n * 65536 + int'(vmem1.write_addr[n*ADDR_W +: ADDR_W])] =
                        vmem1.write_data[n*DATA_W +: DATA_W];
                end
                if (vmem2.write_req[n]) begin
                    mem2_store[n * 65536 + int'(vmem2.write_addr[n*ADDR_W +: ADDR_W])] =
                        vmem2.write_data[n*DATA_W +: DATA_W];
                end
            end
        end
    end

    // ========================================================================
    // instruction stimulus
    // ========================================================================
    task automatic send(input shuffle_instr_t v);
        @(negedge clk);
        instr = v;
    endtask

    // bit 0 of dest id picks the walker, value spans the source fields
    function automatic shuffle_instr_t config_instr(input logic wr_side,
                                                    input shuffle_fn_e fn,
                                                    input logic [15:0] value);
        shuffle_instr_t v;
        v         = '0;
        v.opcode  = OPCODE_W'(PERMUTE_OPCODE);
        v.fn      = fn;
        v.dest_id = wr_side ? mem_id_t'(VMEM2_ID) : mem_id_t'(VMEM1_ID);
        {v.src1_id, v.src1_index, v.src2_id, v.src2_index} = value;
        return v;
    endfunction

    function automatic shuffle_instr_t start_instr();
        shuffle_instr_t v;
        v            = '0;
        v.opcode     = OPCODE_W'(PERMUTE_OPCODE);
        v.fn         = START;
        v.dest_id    = dst_id;
        v.src1_id    = src_id;
        v.src2_index = {4'd0, rotate};
        return v;
    endfunction

    // random fields under an opcode that never matches
    task automatic send_foreign();
        shuffle_instr_t v;
        rng      = xorshift(rng);
        v        = shuffle_instr_t'(rng[27:0]);
        v.opcode = {1'b0, rng[30:28]};
        send(v);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            aborted = 1'b1;
            $display("timeout: no done within %0d cycles in test %0s", DONE_TIMEOUT, test_name);
        end
    endtask

    task automatic run_test(input logic reconfigure);
        @(negedge clk);
        mem1_store.delete();
        mem2_store.delete();
        if (reconfigure) begin
            send(config_instr(1'b0, SET_BASE_ADDR, rd_base));
            send(config_instr(1'b0, SET_LOOP_ITER, n_iter));
            send(config_instr(1'b0, SET_LOOP_STRIDE, rd_stride));
            send(config_instr(1'b1, SET_BASE_ADDR, wr_base));
            send(config_instr(1'b1, SET_LOOP_ITER, n_iter));
            send(config_instr(1'b1, SET_LOOP_STRIDE, wr_stride));
        end
        send_foreign();
        send_foreign();
        send(start_instr());
        send('0);
        wait_done();
        if (!aborted) begin
            // watch for stray requests after done
            repeat (QUIET_CYCLES) @(negedge clk);
            test_end = 1'b1;
            @(negedge clk);
            test_end = 1'b0;
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    f [9];
        string line;
        reset     = 1'b1;
        instr     = '0;
        test_end  = 1'b0;
        test_name = '0;
        src_id    = '0;
        dst_id    = '0;
        rotate    = 1'b0;
        rd_base   = '0;
        rd_stride = '0;
        wr_base   = '0;
        wr_stride = '0;
        n_iter    = '0;
        aborted   = 1'b0;
        rng       = SEED;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("tests/shuffle_tests.txt", "r");
        if (fd == 0) begin
            aborted = 1'b1;
            $display("cannot open the test file tests/shuffle_tests.txt");
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                code = $sscanf(line, "%s %d %d %d %h %h %h %h %d %d", test_name,
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (line.len() > 0 && line.getc(0) != "#" && code == 10) begin
                    src_id    = mem_id_t'(f[0]);
                    dst_id    = mem_id_t'(f[1]);
                    rotate    = f[2][0];
                    rd_base   = buf_addr_t'(f[3]);
                    rd_stride = stride_t'(f[4]);
                    wr_base   = buf_addr_t'(f[5]);
                    wr_stride = stride_t'(f[6]);
                    n_iter    = iter_t'(f[7]);
                    run_test(f[8] != 0);
                end
            end
            $fclose(fd);
        end

        $display("tests passed %0d, failed %0d", pass_count,
                 fail_count + (aborted ? 1 : 0));
        if (!aborted && fail_count == 0 && pass_count > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tests/shuffle_checker.sv */
/*
 * Shuffle checker.
 * Predicts every memory request and the done pulse from the case settings.
 */
`timescale 1ns/1ps

module shuffle_checker import shuffler_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  shuffle_instr_t instr,
    input  vmem_port_t     vmem1,
    input  vmem_port_t     vmem2,
    input  logic           done,
    input  logic [127:0]   test_name,
    input  mem_id_t        src_id,
    input  mem_id_t        dst_id,
    input  logic           rotate,
    input  buf_addr_t      rd_base,
    input  stride_t        rd_stride,
    input  buf_addr_t      wr_base,
    input  stride_t        wr_stride,
    input  iter_t          n_iter,
    input  logic           test_end,
    output int             pass_count,
    output int             fail_count
);

    localparam logic [31:0] SEED = 32'h3511aca4;

    // cycle count since START (-1 when idle)
    int t;
    int errors;

    function automatic logic [31:0] next_xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // untouched word of memory m at a lane and address
    function automatic lane_data_t source_word(input mem_id_t m, input int lane,
                                               input buf_addr_t a);
        return next_xorshift(next_xorshift(SEED ^ {5'd0, m, 8'(lane), a}));
    endfunction

    function automatic buf_addr_t element_addr(input buf_addr_t base, input stride_t stride,
                                               input int i);
        return buf_addr_t'(int'(base) + i * int'(stride));
    endfunction

    // an empty run still takes one write walker cycle before the drain
    function automatic int done_cycle();
        return (n_iter == '0 ? 1 : int'(n_iter)) + NUM_LANES + 4;
    endfunction

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %0s cycle %0d %0s: expected %h, actual %h",
                     test_name, t, what, expected, actual);
        end
    endtask

    // ========================================================================
    // per-cycle port check
    // ========================================================================
    task automatic check_port(input string label, input mem_id_t id, input vmem_port_t p);
        int         i;
        int         c;
        int         j;
        lane_mask_t rd_exp;
        lane_mask_t wr_exp;
        lane_data_t d_exp;
        rd_exp = '0;
        wr_exp = '0;
        for (int n = 0; n < NUM_LANES; n++) begin
            // lane n reads element i in cycle 2+i+n
            i = t - 2 - n;
            if (src_id == id && i >= 0 && i < int'(n_iter)) begin
                rd_exp[n] = 1'b1;
                if (p.read_req[n]) begin
                    compare($sformatf("%0s read_addr[%0d]", label, n),
                            32'(element_addr(rd_base, rd_stride, i)),
                            32'(p.read_addr[n*ADDR_W +: ADDR_W]));
                end
            end
            // and writes element i one cycle later
            i = t - 3 - n;
            if (dst_id == id && i >= 0 && i < int'(n_iter)) begin
                wr_exp[n] = 1'b1;
                c = rotate ? (i % NUM_LANES) : n;
                j = i + n - c;
                if (j > int'(n_iter) - 1) begin
                    j = int'(n_iter) - 1;
                end
                d_exp = source_word(src_id, c, element_addr(rd_base, rd_stride, j));
                if (p.write_req[n]) begin
                    compare($sformatf("%0s write_addr[%0d]", label, n),
                            32'(element_addr(wr_base, wr_stride, i)),
                            32'(p.write_addr[n*ADDR_W +: ADDR_W]));
                    compare($sformatf("%0s write_data[%0d]", label, n),
                            d_exp, p.write_data[n*DATA_W +: DATA_W]);
                end
            end
            // a memory that is not selected sees all fields at zero
            if (t > 0 && src_id != id) begin
                compare($sformatf("%0s read_addr[%0d]", label, n), 32'd0,
                        32'(p.read_addr[n*ADDR_W +: ADDR_W]));
            end
            if (t > 0 && dst_id != id) begin
                compare($sformatf("%0s write_addr[%0d]", label, n), 32'd0,
                        32'(p.write_addr[n*ADDR_W +: ADDR_W]));
                compare($sformatf("%0s write_data[%0d]", label, n), 32'd0,
                        p.write_data[n*DATA_W +: DATA_W]);
            end
        end
        compare({label, " read_req"}, 32'(rd_exp), 32'(p.read_req));
        compare({label, " write_req"}, 32'(wr_exp), 32'(p.write_req));
    endtask

    always @(posedge clk) begin
        if (reset) begin
            t          = -1;
            errors     = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            if (t >= 0) begin
                t++;
            end
            check_port("vmem1", mem_id_t'(VMEM1_ID), vmem1);
            check_port("vmem2", mem_id_t'(VMEM2_ID), vmem2);
            compare("done", 32'(t == done_cycle()), 32'(done));
            if (instr.opcode == OPCODE_W'(PERMUTE_OPCODE) && instr.fn == START) begin
                t = 0;
            end
            if (test_end) begin
                if (errors == 0) begin
                    pass_count++;
                    $display("%0s: ok", test_name);
                end else begin
                    fail_count++;
                    $display("%0s: FAILED with %0d mismatches", test_name, errors);
                end
                errors = 0;
                t      = -1;
            end
        end
    end

endmodule

/* verilog/data_shuffler.sv */
/*
 * Tensor data shuffler top level.
 * Strided copy between vector memories with optional bank rotation.
 */
`timescale 1ns/1ps

module data_shuffler import shuffler_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  shuffle_instr_t instr,
    input  lane_data_vec_t vmem1_rdata,
    input  lane_data_vec_t vmem2_rdata,
    output vmem_port_t     vmem1,
    output vmem_port_t     vmem2,
    output logic           done
);

    walker_cfg_t    rd_cfg;
    walker_cfg_t    wr_cfg;
    logic           start;
    mem_id_t        src_id;
    mem_id_t        dst_id;
    logic           rotate;
    logic           rd_start;
    logic           wr_start;
    logic           wr_last;
    buf_addr_t      rd_addr;
    logic           rd_addr_v;
    buf_addr_t      wr_addr;
    logic           wr_addr_v;
    lane_mask_t     rd_lane_req;
    lane_addr_vec_t rd_lane_addr;
    lane_mask_t     wr_lane_req;
    lane_addr_vec_t wr_lane_addr;
    lane_data_vec_t rd_data;
    lane_data_vec_t wr_data;

    // ========================================================================
    // control
    // ========================================================================
    shuffle_decoder decoder_i (
        .clk    (clk),
        .reset  (reset),
        .instr  (instr),
        .rd_cfg (rd_cfg),
        .wr_cfg (wr_cfg),
        .start  (start),
        .src_id (src_id),
        .dst_id (dst_id),
        .rotate (rotate)
    );

    shuffle_sequencer sequencer_i (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .wr_last  (wr_last),
        .rd_start (rd_start),
        .wr_start (wr_start),
        .done     (done)
    );

    stride_walker rd_walker (
        .clk    (clk),
        .reset  (reset),
        .cfg    (rd_cfg),
        .start  (rd_start),
        .addr   (rd_addr),
        .addr_v (rd_addr_v),
        .last   ()
    );

    stride_walker wr_walker (
        .clk    (clk),
        .reset  (reset),
        .cfg    (wr_cfg),
        .start  (wr_start),
        .addr   (wr_addr),
        .addr_v (wr_addr_v),
        .last   (wr_last)
    );

    // ========================================================================
    // datapath
    // ========================================================================
    lane_skew rd_skew (
        .clk       (clk),
        .reset     (reset),
        .req       (rd_addr_v),
        .addr      (rd_addr),
        .lane_req  (rd_lane_req),
        .lane_addr (rd_lane_addr)
    );

    lane_skew wr_skew (
        .clk       (clk),
        .reset     (reset),
        .req       (wr_addr_v),
        .addr      (wr_addr),
        .lane_req  (wr_lane_req),
        .lane_addr (wr_lane_addr)
    );

    // counters step with each lane write, restart with the read walker
    bank_rotator rotator_i (
        .clk     (clk),
        .reset   (reset),
        .clear   (rd_start),
        .lane_en (wr_lane_req),
        .rotate  (rotate),
        .rd_data (rd_data),
        .wr_data (wr_data)
    );

    vmem_port_mux port_mux_i (
        .src_id      (src_id),
        .dst_id      (dst_id),
        .rd_req      (rd_lane_req),
        .rd_addr     (rd_lane_addr),
        .wr_req      (wr_lane_req),
        .wr_addr     (wr_lane_addr),
        .wr_data     (wr_data),
        .vmem1_rdata (vmem1_rdata),
        .vmem2_rdata (vmem2_rdata),
        .vmem1       (vmem1),
        .vmem2       (vmem2),
        .rd_data     (rd_data)
    );

endmodule

/* datapath/vmem_port_mux.sv */
/*
 * Vector memory port routing.
 * Sends reads to the source memory, writes to the destination memory.
 */
`timescale 1ns/1ps

module vmem_port_mux import shuffler_pkg::*; (
    input  mem_id_t        src_id,
    input  mem_id_t        dst_id,
    input  lane_mask_t     rd_req,
    input  lane_addr_vec_t rd_addr,
    input  lane_mask_t     wr_req,
    input  lane_addr_vec_t wr_addr,
    input  lane_data_vec_t wr_data,
    input  lane_data_vec_t vmem1_rdata,
    input  lane_data_vec_t vmem2_rdata,
    output vmem_port_t     vmem1,
    output vmem_port_t     vmem2,
    output lane_data_vec_t rd_data
);

    always_comb begin
        // unselected memory sees nothing
        vmem1   = '0;
        vmem2   = '0;
        rd_data = '0;
        case (src_id)
            mem_id_t'(VMEM1_ID): begin
                vmem1.read_req  = rd_req;
                vmem1.read_addr = rd_addr;
                rd_data         = vmem1_rdata;
            end
            mem_id_t'(VMEM2_ID): begin
                vmem2.read_req  = rd_req;
                vmem2.read_addr = rd_addr;
                rd_data         = vmem2_rdata;
            end
            default: rd_data = '0;
        endcase
        // same memory on both sides is allowed
        case (dst_id)
            mem_id_t'(VMEM1_ID): begin
                vmem1.write_req  = wr_req;
                vmem1.write_addr = wr_addr;
                vmem1.write_data = wr_data;
            end
            mem_id_t'(VMEM2_ID): begin
                vmem2.write_req  = wr_req;
                vmem2.write_addr = wr_addr;
                vmem2.write_data = wr_data;
            end
            default: ;
        endcase
    end

    // ids latched at start must name a real memory once lanes are busy
    always_comb begin
        if (|rd_req) begin
            a_src_known: assert (src_id inside {VMEM1_ID, VMEM2_ID});
        end
        if (|wr_req) begin
            a_dst_known: assert (dst_id inside {VMEM1_ID, VMEM2_ID});
        end
    end

endmodule

/* datapath/bank_rotator.sv */
/*
 * Bank rotation for the write data.
 * Per-lane counters pick which source lane feeds each destination lane.
 */
`timescale 1ns/1ps

module bank_rotator import shuffler_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           clear,
    input  lane_mask_t     lane_en,
    input  logic           rotate,
    input  lane_data_vec_t rd_data,
    output lane_data_vec_t wr_data
);

    logic [LANE_IDX_W-1:0] bank_cnt_q [NUM_LANES];

    // one count per written element, cleared at every run start
    always_ff @(posedge clk) begin
        for (int n = 0; n < NUM_LANES; n++) begin
            if (reset || clear) begin
                bank_cnt_q[n] <= '0;
            end else if (lane_en[n]) begin
                if (bank_cnt_q[n] == LANE_IDX_W'(NUM_LANES - 1)) begin
                    bank_cnt_q[n] <= '0;
                end else begin
                    bank_cnt_q[n] <= bank_cnt_q[n] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        logic [LANE_IDX_W-1:0] sel;
        sel = '0;
        for (int n = 0; n < NUM_LANES; n++) begin
            // straight copy keeps lane n on lane n
            sel = rotate ? bank_cnt_q[n] : LANE_IDX_W'(n);
            wr_data[n*DATA_W +: DATA_W] = rd_data[sel*DATA_W +: DATA_W];
        end
    end

endmodule

/* datapath/lane_skew.sv */
/*
 * Lane wavefront delay chain.
 * Lane n sees the request and address of lane 0 n cycles later.
 */
`timescale 1ns/1ps

module lane_skew import shuffler_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           req,
    input  buf_addr_t      addr,
    output lane_mask_t     lane_req,
    output lane_addr_vec_t lane_addr
);

    logic [NUM_LANES-1:1] req_q;
    buf_addr_t            addr_q [NUM_LANES-1:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= '0;
        end else begin
            req_q[1] <= req;
            for (int n = 2; n < NUM_LANES; n++) begin
                req_q[n] <= req_q[n-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q[1] <= addr;
        for (int n = 2; n < NUM_LANES; n++) begin
            addr_q[n] <= addr_q[n-1];
        end
    end

    // lane 0 goes straight through
    always_comb begin
        lane_req[0]            = req;
        lane_addr[ADDR_W-1:0]  = addr;
        for (int n = 1; n < NUM_LANES; n++) begin
            lane_req[n]                 = req_q[n];
            lane_addr[n*ADDR_W +: ADDR_W] = addr_q[n];
        end
    end

endmodule

/* control/stride_walker.sv */
/*
 * Strided address walker, one loop.
 * Emits base + k*stride for k = 0..N-1, one address per cycle after start.
 */
`timescale 1ns/1ps

module stride_walker import shuffler_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  walker_cfg_t cfg,
    input  logic        start,
    output buf_addr_t   addr,
    output logic        addr_v,
    output logic        last
);

    buf_addr_t base_q;
    stride_t   stride_q;
    iter_t     iter_q;
    buf_addr_t addr_q;
    iter_t     remain_q;
    logic      active_q;

    // ========================================================================
    // configuration
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            iter_q <= '0;
        end else if (cfg.iter_v) begin
            iter_q <= cfg.value;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg.base_v) begin
            base_q <= cfg.value;
        end
        if (cfg.stride_v) begin
            stride_q <= cfg.value;
        end
    end

    // ========================================================================
    // walk
    // ========================================================================
    // active covers N cycles, or a single empty cycle when N is zero
    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= 1'b0;
            remain_q <= '0;
        end else if (start) begin
            active_q <= 1'b1;
            remain_q <= iter_q;
        end else if (active_q) begin
            if (remain_q <= iter_t'(1)) begin
                active_q <= 1'b0;
            end else begin
                remain_q <= remain_q - 1'b1;
            end
        end
    end

    // address wraps at 16 bits
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= base_q;
        end else if (active_q) begin
            addr_q <= addr_q + stride_q;
        end
    end

    assign addr   = addr_q;
    assign addr_v = active_q && (remain_q != '0);
    assign last   = active_q && (remain_q <= iter_t'(1));

    a_no_cfg_while_active: assert property (@(posedge clk) disable iff (reset)
        (cfg.base_v || cfg.iter_v || cfg.stride_v) |-> !active_q);

endmodule

/* control/shuffle_sequencer.sv */
/*
 * Shuffle run sequencer.
 * Staggers walker starts and drains the lane wavefront before done.
 */
`timescale 1ns/1ps

module shuffle_sequencer import shuffler_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic wr_last,
    output logic rd_start,
    output logic wr_start,
    output logic done
);

    seq_state_e state_q;
    seq_state_e state_d;
    // one extra bit so the counter can hold DRAIN_CYCLES
    logic [LANE_IDX_W:0] drain_q;
    logic [LANE_IDX_W:0] drain_d;

    // read walker one cycle after start, write walker one more
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            rd_start <= start;
            wr_start <= rd_start;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            drain_q <= '0;
        end else begin
            state_q <= state_d;
            drain_q <= drain_d;
        end
    end

    always_comb begin
        state_d = state_q;
        drain_d = drain_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = BUSY;
                end
            end
            BUSY: begin
                if (wr_last) begin
                    state_d = DRAIN;
                    drain_d = (LANE_IDX_W + 1)'(DRAIN_CYCLES);
                end
            end
            DRAIN: begin
                if (drain_q == '0) begin
                    state_d = DONE;
                end else begin
                    drain_d = drain_q - 1'b1;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign done = (state_q == DONE);

    // decoder must not issue a new run before done
    a_start_in_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> state_q == IDLE);

endmodule

/* control/shuffle_decoder.sv */
/*
 * Shuffle instruction decoder.
 * Steers config writes to the read or write walker, latches ids on start.
 */
`timescale 1ns/1ps

module shuffle_decoder import shuffler_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  shuffle_instr_t instr,
    output walker_cfg_t    rd_cfg,
    output walker_cfg_t    wr_cfg,
    output logic           start,
    output mem_id_t        src_id,
    output mem_id_t        dst_id,
    output logic           rotate
);

    logic              is_perm;
    logic              to_wr;
    logic [ADDR_W-1:0] cfg_value;
    walker_cfg_t       cfg;

    assign is_perm = (instr.opcode == OPCODE_W'(PERMUTE_OPCODE));
    // dest id bit 0 picks the write side
    assign to_wr   = instr.dest_id[0];

    // immediate value spans both source fields
    assign cfg_value = {instr.src1_id, instr.src1_index, instr.src2_id, instr.src2_index};

    always_comb begin
        cfg.base_v   = is_perm && (instr.fn == SET_BASE_ADDR);
        cfg.iter_v   = is_perm && (instr.fn == SET_LOOP_ITER);
        cfg.stride_v = is_perm && (instr.fn == SET_LOOP_STRIDE);
        cfg.value    = cfg_value;

        rd_cfg          = cfg;
        rd_cfg.base_v   = cfg.base_v && !to_wr;
        rd_cfg.iter_v   = cfg.iter_v && !to_wr;
        rd_cfg.stride_v = cfg.stride_v && !to_wr;

        wr_cfg          = cfg;
        wr_cfg.base_v   = cfg.base_v && to_wr;
        wr_cfg.iter_v   = cfg.iter_v && to_wr;
        wr_cfg.stride_v = cfg.stride_v && to_wr;
    end

    assign start = is_perm && (instr.fn == START);

    // memory selection and mode hold for the whole run
    always_ff @(posedge clk) begin
        if (reset) begin
            src_id <= '0;
            dst_id <= '0;
            rotate <= 1'b0;
        end else if (start) begin
            src_id <= instr.src1_id;
            dst_id <= instr.dest_id;
            rotate <= instr.src2_index[0];
        end
    end

endmodule

/* common/shuffler_pkg.sv */
/*
 * Tensor data shuffler shared definitions.
 * Widths, namespace ids, opcode, instruction and port structs.
 */
package shuffler_pkg;

    // ========================================================================
    // sizes and ids
    // ========================================================================
    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = 2;
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 16;
    localparam int ITER_W     = 16;
    localparam int STRIDE_W   = 16;
    localparam int OPCODE_W   = 4;
    localparam int NS_IDX_W   = 5;

    localparam int VMEM1_ID       = 2;
    localparam int VMEM2_ID       = 3;
    localparam int PERMUTE_OPCODE = 8;

    // write side needs one cycle per lane to finish its wavefront
    localparam int DRAIN_CYCLES = NUM_LANES;

    typedef logic [DATA_W-1:0]           lane_data_t;
    typedef logic [ADDR_W-1:0]           buf_addr_t;
    typedef logic [ITER_W-1:0]           iter_t;
    typedef logic [STRIDE_W-1:0]         stride_t;
    typedef logic [2:0]                  mem_id_t;
    typedef logic [NUM_LANES-1:0]        lane_mask_t;
    typedef logic [NUM_LANES*ADDR_W-1:0] lane_addr_vec_t;
    typedef logic [NUM_LANES*DATA_W-1:0] lane_data_vec_t;

    typedef enum logic [3:0] {
        SET_BASE_ADDR   = 4'd0,
        SET_LOOP_ITER   = 4'd1,
        SET_LOOP_STRIDE = 4'd2,
        START           = 4'd3
    } shuffle_fn_e;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DRAIN,
        DONE
    } seq_state_e;

    // ========================================================================
    // structs
    // ========================================================================
    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        shuffle_fn_e         fn;
        mem_id_t             dest_id;
        logic [NS_IDX_W-1:0] dest_index;
        mem_id_t             src1_id;
        logic [NS_IDX_W-1:0] src1_index;
        mem_id_t             src2_id;
        logic [NS_IDX_W-1:0] src2_index;
    } shuffle_instr_t;

    // one config write, at most one valid bit set
    typedef struct packed {
        logic              base_v;
        logic              iter_v;
        logic              stride_v;
        logic [ADDR_W-1:0] value;
    } walker_cfg_t;

    typedef struct packed {
        lane_mask_t     write_req;
        lane_addr_vec_t write_addr;
        lane_data_vec_t write_data;
        lane_mask_t     read_req;
        lane_addr_vec_t read_addr;
    } vmem_port_t;

endpackage
